/* metricPkg.sv */
`default_nettype none

package metricPkg;

   localparam int metricWidth = 12;        // default signed metric width
   localparam int indexWidth  = 5;         // room for larger trellises
   localparam int numMetrics  = 16;        // path metrics per symbol
   localparam int groupSize   = 4;         // metrics per first-stage comparator
   localparam int numGroups   = numMetrics / groupSize;

   // one signed path metric
   typedef logic signed [metricWidth-1:0] metric_t;

   // branch index of a path metric
   typedef logic [indexWidth-1:0] index_t;

   // all metrics of one symbol, metric 0 in the lowest bits
   typedef logic [numMetrics*metricWidth-1:0] metricBus_t;

endpackage

`default_nettype wire

/* maxOfFour.sv */
`timescale 1ns/100ps
`default_nettype none

module maxOfFour #(
   parameter int metricWidth = metricPkg::metricWidth,
   parameter int indexOffset = 0
) (
   input  wire                     clk,
   input  wire [metricWidth-1:0]   a,
   input  wire [metricWidth-1:0]   b,
   input  wire [metricWidth-1:0]   c,
   input  wire [metricWidth-1:0]   d,
   output metricPkg::index_t       index,
   output logic [metricWidth-1:0]  maxVal
);

   import metricPkg::*;

   logic                   selAb;      // b beats a
   logic                   selCd;      // d beats c
   logic                   selPair;    // c/d winner beats a/b winner
   logic [metricWidth-1:0] winAb;
   logic [metricWidth-1:0] winCd;
   logic [1:0]             localIdx;   // position 0..3 inside the group

   // high when y is at least x, so a tie goes to the later operand
   function automatic logic laterWins(
      input logic [metricWidth-1:0] x,
      input logic [metricWidth-1:0] y
   );
      logic result;
      case ({x[metricWidth-1], y[metricWidth-1]})
         2'b01:
         begin
            result = 1'b0;   // x positive, y negative
         end
         2'b10:
         begin
            result = 1'b1;   // x negative, y positive
         end
         default:
         begin
            // equal signs let the raw two's complement bits order correctly
            result = (y >= x);
         end
      endcase
      return result;
   endfunction

   assign selAb = laterWins(a, b);
   assign selCd = laterWins(c, d);
   assign winAb = selAb ? b : a;
   assign winCd = selCd ? d : c;

   assign selPair  = laterWins(winAb, winCd);
   assign localIdx = {selPair, selPair ? selCd : selAb};

   // group winner and its branch index
   always_ff @(posedge clk)
   begin
      index  <= index_t'(localIdx) + index_t'(indexOffset);
      maxVal <= selPair ? winCd : winAb;
   end

endmodule

`default_nettype wire

/* maxMerge.sv */
`timescale 1ns/100ps
`default_nettype none

module maxMerge #(
   parameter int metricWidth = metricPkg::metricWidth
) (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     inValid,
   input  wire [metricWidth-1:0]   val0,
   input  wire [metricWidth-1:0]   val1,
   input  wire [metricWidth-1:0]   val2,
   input  wire [metricWidth-1:0]   val3,
   input  wire metricPkg::index_t  idx0,
   input  wire metricPkg::index_t  idx1,
   input  wire metricPkg::index_t  idx2,
   input  wire metricPkg::index_t  idx3,
   output logic                    outValid,
   output logic [metricWidth-1:0]  outMax,
   output metricPkg::index_t       outIndex
);

   import metricPkg::*;

   logic                   sel01;   // group 1 beats group 0
   logic                   sel23;   // group 3 beats group 2
   logic                   selTop;  // upper pair beats lower pair
   logic [metricWidth-1:0] win01;
   logic [metricWidth-1:0] win23;
   index_t                 idx01;
   index_t                 idx23;

   // high when y is at least x, ties go to the later group
   function automatic logic laterWins(
      input logic [metricWidth-1:0] x,
      input logic [metricWidth-1:0] y
   );
      logic result;
      case ({x[metricWidth-1], y[metricWidth-1]})
         2'b01:
         begin
            result = 1'b0;   // x positive, y negative
         end
         2'b10:
         begin
            result = 1'b1;   // x negative, y positive
         end
         default:
         begin
            result = (y >= x);   // same sign, magnitude decides
         end
      endcase
      return result;
   endfunction

   assign sel01 = laterWins(val0, val1);
   assign sel23 = laterWins(val2, val3);
   assign win01 = sel01 ? val1 : val0;
   assign win23 = sel23 ? val3 : val2;
   assign idx01 = sel01 ? idx1 : idx0;   // carried index passes through
   assign idx23 = sel23 ? idx3 : idx2;

   assign selTop = laterWins(win01, win23);

   always_ff @(posedge clk)
   begin
      if (rst)
         outValid <= 1'b0;
      else
         outValid <= inValid;
   end

   always_ff @(posedge clk)
   begin
      outMax   <= selTop ? win23 : win01;
      outIndex <= selTop ? idx23 : idx01;
   end

endmodule

`default_nettype wire

/* metricNormalizer.sv */
`timescale 1ns/100ps
`default_nettype none

module metricNormalizer #(
   parameter int metricWidth = metricPkg::metricWidth
) (
   input  wire                                                clk,
   input  wire                                                rst,
   input  wire                                                inValid,
   input  wire [metricPkg::numMetrics*metricWidth-1:0]        metrics,
   input  wire [metricWidth-1:0]                              winMax,
   input  wire metricPkg::index_t                             winIndex,
   output logic [metricPkg::numMetrics*metricWidth-1:0]       normMetrics,
   output logic [metricWidth-1:0]                             maxValue,
   output metricPkg::index_t                                  maxIndex,
   output logic                                               resultValid
);

   import metricPkg::*;

   localparam int busWidth = numMetrics * metricWidth;

   logic [busWidth-1:0] metricsD1;   // lines up with the group winners
   logic [busWidth-1:0] metricsD2;   // lines up with the merged winner
   logic [busWidth-1:0] normNext;

   always_ff @(posedge clk)
   begin
      metricsD1 <= metrics;
      metricsD2 <= metricsD1;
   end

   for (genvar i = 0; i < numMetrics; i++)
   begin : gSub
      logic [metricWidth-1:0] m;
      logic [metricWidth:0]   diff;   // one guard bit

      assign m    = metricsD2[i*metricWidth +: metricWidth];
      assign diff = {m[metricWidth-1], m} - {winMax[metricWidth-1], winMax};

      // guard and sign bit disagree only when the result left the metric range;
      // since winMax is the maximum this can only happen on the negative side
      assign normNext[i*metricWidth +: metricWidth] =
         (diff[metricWidth] != diff[metricWidth-1]) ?
         {diff[metricWidth], {(metricWidth-1){~diff[metricWidth]}}} :
         diff[metricWidth-1:0];
   end

   always_ff @(posedge clk)
   begin
      normMetrics <= normNext;
      maxValue    <= winMax;
      maxIndex    <= winIndex;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         resultValid <= 1'b0;
      else
         resultValid <= inValid;   // third and last valid stage
   end

endmodule

`default_nettype wire

/* maxMetricSelect.sv */
`timescale 1ns/100ps
`default_nettype none

module maxMetricSelect #(
   parameter int metricWidth = metricPkg::metricWidth
) (
   input  wire                                             clk,
   input  wire                                             rst,
   input  wire [metricPkg::numMetrics*metricWidth-1:0]     metrics,
   input  wire                                             metricValid,
   output metricPkg::index_t                               maxIndex,
   output logic [metricWidth-1:0]                          maxValue,
   output logic [metricPkg::numMetrics*metricWidth-1:0]    normMetrics,
   output logic                                            resultValid
);

   import metricPkg::*;

   logic                   stage1Valid;             // comparators carry no valid bit
   logic [metricWidth-1:0] groupMax [numGroups];
   index_t                 groupIndex [numGroups];
   logic                   mergedValid;
   logic [metricWidth-1:0] mergedMax;
   index_t                 mergedIndex;

   always_ff @(posedge clk)
   begin
      if (rst)
         stage1Valid <= 1'b0;
      else
         stage1Valid <= metricValid;
   end

   // stage 1, group k covers metrics 4k to 4k+3
   for (genvar k = 0; k < numGroups; k++)
   begin : gGroup
      localparam int base = k * groupSize * metricWidth;

      maxOfFour #(
         .metricWidth (metricWidth),
         .indexOffset (k * groupSize)
      ) uComp (
         .clk    (clk),
         .a      (metrics[base                 +: metricWidth]),
         .b      (metrics[base +   metricWidth +: metricWidth]),
         .c      (metrics[base + 2*metricWidth +: metricWidth]),
         .d      (metrics[base + 3*metricWidth +: metricWidth]),
         .index  (groupIndex[k]),
         .maxVal (groupMax[k])
      );
   end

   maxMerge #(
      .metricWidth (metricWidth)
   ) uMerge (
      .clk      (clk),
      .rst      (rst),
      .inValid  (stage1Valid),
      .val0     (groupMax[0]),
      .val1     (groupMax[1]),
      .val2     (groupMax[2]),
      .val3     (groupMax[3]),
      .idx0     (groupIndex[0]),
      .idx1     (groupIndex[1]),
      .idx2     (groupIndex[2]),
      .idx3     (groupIndex[3]),
      .outValid (mergedValid),
      .outMax   (mergedMax),
      .outIndex (mergedIndex)
   );

   metricNormalizer #(
      .metricWidth (metricWidth)
   ) uNorm (
      .clk         (clk),
      .rst         (rst),
      .inValid     (mergedValid),
      .metrics     (metrics),       // delayed inside to meet its own maximum
      .winMax      (mergedMax),
      .winIndex    (mergedIndex),
      .normMetrics (normMetrics),
      .maxValue    (maxValue),
      .maxIndex    (maxIndex),
      .resultValid (resultValid)
   );

endmodule

`default_nettype wire

/* maxMetricSelect_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module maxMetricSelect_properties #(
   parameter int metricWidth = metricPkg::metricWidth
) (
   input wire                                          clk,
   input wire                                          rst,
   input wire                                          metricValid,
   input wire                                          resultValid,
   input wire metricPkg::index_t                       maxIndex,
   input wire [metricPkg::numMetrics*metricWidth-1:0]  normMetrics
);

   import metricPkg::*;

   // strobe leaves exactly three cycles after it enters unless a reset came between
   strobeLatency: assert property (
      @(posedge clk) disable iff (rst)
      resultValid == ($past(metricValid, 3) &&
                      !$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3))
   ) else $error("resultValid does not follow metricValid by three cycles");

   lowAfterReset: assert property (
      @(posedge clk) rst |=> !resultValid
   ) else $error("resultValid high right after reset");

   indexRange: assert property (
      @(posedge clk) disable iff (rst)
      resultValid |-> maxIndex < index_t'(numMetrics)
   ) else $error("maxIndex out of range");

   // winner minus itself
   winnerZero: assert property (
      @(posedge clk) disable iff (rst)
      resultValid |-> normMetrics[maxIndex*metricWidth +: metricWidth] == '0
   ) else $error("normalized metric at maxIndex is not zero");

endmodule

bind maxMetricSelect maxMetricSelect_properties #(
   .metricWidth (metricWidth)
) uProps (
   .clk         (clk),
   .rst         (rst),
   .metricValid (metricValid),
   .resultValid (resultValid),
   .maxIndex    (maxIndex),
   .normMetrics (normMetrics)
);

`default_nettype wire

/* tb_maxMetricSelect.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_maxMetricSelect;

   import metricPkg::*;

   localparam int clkPeriod   = 40;
   localparam int driveDelay  = 2;
   localparam int wordsPerVec = numMetrics + 2;   // metrics, index, maximum
   localparam int maxWords    = 64 * wordsPerVec;
   localparam int drainLimit  = 20;              // cycles

   logic        clk = 1'b0;
   logic        rst;
   metricBus_t  metrics;
   logic        metricValid;
   index_t      maxIndex;
   metric_t     maxValue;
   metricBus_t  normMetrics;
   logic        resultValid;

   logic [15:0] fileWords [maxWords];
   metricBus_t  expBus [$];     // expected normalized bus
   index_t      expIdx [$];
   metric_t     expMax [$];
   int          expCycle [$];   // cycle of the input strobe
   int          cycleCount = 0;
   int          valueErrors = 0;
   int          otherErrors = 0;
   int          numVectors;
   integer      seed;

   maxMetricSelect uut (
      .clk         (clk),
      .rst         (rst),
      .metrics     (metrics),
      .metricValid (metricValid),
      .maxIndex    (maxIndex),
      .maxValue    (maxValue),
      .normMetrics (normMetrics),
      .resultValid (resultValid)
   );

   always #(clkPeriod / 2) clk = ~clk;

   always @(posedge clk)
      cycleCount <= cycleCount + 1;

   // upward scan where an equal later metric takes over
   function automatic void refMax(input metricBus_t bus, output index_t idx, output metric_t mx);
      metric_t m;
      idx = '0;
      mx  = metric_t'(bus[metricWidth-1:0]);
      for (int i = 1; i < numMetrics; i++)
      begin
         m = metric_t'(bus[i*metricWidth +: metricWidth]);
         if (m >= mx)
         begin
            mx  = m;
            idx = index_t'(i);
         end
      end
   endfunction

   function automatic metricBus_t normRef(input metricBus_t bus, input metric_t mx);
      metricBus_t res;
      int         diff;
      int         lowest;
      lowest = -(1 << (metricWidth - 1));
      for (int i = 0; i < numMetrics; i++)
      begin
         diff = int'(metric_t'(bus[i*metricWidth +: metricWidth])) - int'(mx);
         if (diff < lowest)
            diff = lowest;   // clip at the negative limit
         res[i*metricWidth +: metricWidth] = diff[metricWidth-1:0];
      end
      return res;
   endfunction

   function automatic metricBus_t fileBus(input int v);
      metricBus_t bus;
      for (int i = 0; i < numMetrics; i++)
         bus[i*metricWidth +: metricWidth] = fileWords[v*wordsPerVec + i][metricWidth-1:0];
      return bus;
   endfunction

   function automatic metricBus_t randomBus(input bit extremes);
      metricBus_t bus;
      int         r;
      for (int i = 0; i < numMetrics; i++)
      begin
         r = $random(seed);
         if (extremes)
            bus[i*metricWidth +: metricWidth] = {r[1], {(metricWidth-1){r[0]}}};  // 0, -1, min, max
         else
            bus[i*metricWidth +: metricWidth] = r[metricWidth-1:0];
      end
      return bus;
   endfunction

   task automatic driveVector(input metricBus_t bus, input index_t idx, input metric_t mx);
      @(posedge clk);
      #driveDelay;
      metrics     = bus;
      metricValid = 1'b1;
      expBus.push_back(normRef(bus, mx));
      expIdx.push_back(idx);
      expMax.push_back(mx);
      expCycle.push_back(cycleCount);
   endtask

   task automatic idleCycle();
      @(posedge clk);
      #driveDelay;
      metricValid = 1'b0;
      metrics     = randomBus(1'b0);   // junk without a strobe
   endtask

   task automatic finishRun();
      $display("Error counts: %0d value, %0d other", valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   endtask

   task automatic waitDrain();
      int n;
      n = 0;
      while (expIdx.size() != 0 && n < drainLimit)
      begin
         idleCycle();
         n++;
      end
      if (expIdx.size() != 0)
      begin
         otherErrors++;
         $display("Timeout: %0d results missing after %0d cycles", expIdx.size(), drainLimit);
         finishRun();
      end
   endtask

   task automatic checkResult();
      metricBus_t eBus;
      index_t     eIdx;
      metric_t    eMax;
      int         eCyc;
      metric_t    got;
      metric_t    want;
      assert (expIdx.size() != 0)
      else
      begin
         otherErrors++;
         $display("resultValid pulsed at %0t with no vector in flight", $time);
      end
      if (expIdx.size() != 0)
      begin
         eBus = expBus.pop_front();
         eIdx = expIdx.pop_front();
         eMax = expMax.pop_front();
         eCyc = expCycle.pop_front();
         assert (cycleCount - eCyc == 3)
         else
         begin
            otherErrors++;
            $display("Result at %0t came %0d cycles after its strobe", $time, cycleCount - eCyc);
         end
         assert (maxIndex == eIdx)
         else
         begin
            valueErrors++;
            $display("** Error at %0t: maxIndex = %0d, expected %0d", $time, maxIndex, eIdx);
         end
         assert (maxValue == eMax)
         else
         begin
            valueErrors++;
            $display("** Error at %0t: maxValue = %0d, expected %0d", $time, maxValue, eMax);
         end
         for (int i = 0; i < numMetrics; i++)
         begin
            got  = metric_t'(normMetrics[i*metricWidth +: metricWidth]);
            want = metric_t'(eBus[i*metricWidth +: metricWidth]);
            assert (got == want)
            else
            begin
               valueErrors++;
               $display("** Error at %0t: normMetrics[%0d] = %0d, expected %0d",
                        $time, i, got, want);
            end
         end
      end
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk)
   begin
      if (!rst && resultValid)
         checkResult();
   end

   task automatic midStreamReset();
      metricBus_t bus;
      index_t     idx;
      metric_t    mx;
      for (int v = 0; v < 3; v++)
      begin
         bus = randomBus(1'b0);
         refMax(bus, idx, mx);
         driveVector(bus, idx, mx);
      end
      // strobe stays high through the single reset cycle
      @(posedge clk);
      #driveDelay;
      rst = 1'b1;   // vectors still in flight are dropped
      expBus.delete();
      expIdx.delete();
      expMax.delete();
      expCycle.delete();
      @(posedge clk);
      #driveDelay;
      assert (resultValid == 1'b0)
      else
      begin
         otherErrors++;
         $display("resultValid still high at %0t after a mid-stream reset", $time);
      end
      rst         = 1'b0;
      metricValid = 1'b0;
      repeat (6) idleCycle();   // a stale result would be flagged here
   endtask

   initial
   begin
      metricBus_t bus;
      index_t     idx;
      metric_t    mx;
      rst         = 1'b1;
      metrics     = '0;
      metricValid = 1'b0;
      seed        = 32'h563d_e4a2;
      for (int a = 0; a < maxWords; a++)
         fileWords[a] = {4'hf, a[11:0]};   // upper nibble marks an unread word
      $readmemh("maxMetricSelect_tests.txt", fileWords);
      numVectors = 0;
      while (numVectors < maxWords / wordsPerVec &&
             fileWords[numVectors*wordsPerVec][15:12] == 4'h0)
         numVectors++;
      assert (numVectors > 0)
      else
      begin
         otherErrors++;
         $display("No vectors found in maxMetricSelect_tests.txt");
      end

      repeat (8) @(posedge clk);
      #driveDelay;
      rst = 1'b0;

      // one vector at a time
      for (int v = 0; v < numVectors; v++)
      begin
         driveVector(fileBus(v), index_t'(fileWords[v*wordsPerVec + numMetrics]),
                     metric_t'(fileWords[v*wordsPerVec + numMetrics + 1]));
         waitDrain();
      end

      // same vectors back to back
      for (int v = 0; v < numVectors; v++)
         driveVector(fileBus(v), index_t'(fileWords[v*wordsPerVec + numMetrics]),
                     metric_t'(fileWords[v*wordsPerVec + numMetrics + 1]));
      waitDrain();

      midStreamReset();

      for (int v = 0; v < 200; v++)
      begin
         bus = randomBus(v % 4 == 0);
         refMax(bus, idx, mx);
         driveVector(bus, idx, mx);
         if (($random(seed) & 3) == 0)
            idleCycle();   // occasional gap
      end
      waitDrain();

      finishRun();
   end

endmodule

`default_nettype wire

/* maxMetricSelect.f */
metricPkg.sv
maxOfFour.sv
maxMerge.sv
metricNormalizer.sv
maxMetricSelect.sv
maxMetricSelect_properties.sv
tb_maxMetricSelect.sv

/* Makefile */
# Verilator build and run for the max metric selector

VERILATOR ?= verilator
TOP       ?= tb_maxMetricSelect
FILELIST  ?= maxMetricSelect.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed
FAIL_MSG  ?= Checks failed

SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED, no pass line"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)

/* maxMetricSelect_tests.txt */
// columns: m0 .. m15 as 12-bit signed hex, metric 0 first,
// then the expected winning index and the expected maximum
// maximum in each of the four groups, mixed signs
123 fff 022 800 100 f00 0ff 001 000 ed0 050 122 fa0 011 0aa 800 00 123
001 002 003 004 100 3e8 fff 200 0c8 c00 064 3e7 1f4 800 010 005 05 3e8
7fe 000 fff 001 400 401 c00 3ff 123 7fd 7ff 7fe 800 001 002 003 0a 7ff
fff ffe ffd ffc 04f 000 800 020 030 fc0 001 002 003 004 050 04e 0e 050
// all negative
ff8 ff0 f00 800 fa0 ffb f38 c18 900 ffd fe0 fc0 801 f01 ff1 e00 09 ffd
800 800 800 800 800 800 800 801 800 800 800 800 800 800 800 800 07 801
// single positive metric, saturation at the negative limit
fff fff fff fff fff fff fff fff fff fff fff fff 001 fff fff fff 0c 001
800 800 800 7ff 800 800 800 800 800 800 800 800 800 800 800 800 03 7ff
800 c00 bff 000 801 3ff 400 c01 800 fff 001 200 800 c00 bfe 3ff 06 400
// all equal, highest index wins
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 0f 000
800 800 800 800 800 800 800 800 800 800 800 800 800 800 800 800 0f 800
7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 0f 7ff
// ties inside one group
100 000 fff 200 2aa 001 2aa 2a9 800 000 111 222 2a0 0aa fff 001 06 2aa
000 000 000 000 000 000 000 000 345 344 100 345 300 fff 800 001 0b 345
// ties across groups
111 5a5 222 333 444 555 000 fff 5a4 100 800 0ff 5a0 5a5 123 456 0d 5a5
f00 f10 f20 ff9 f30 f40 f50 f60 f70 ff9 f80 f90 fa0 fb0 fc0 fd0 09 ff9
7ff 7fe 000 800 001 7fe 7fd 000 800 800 7fe 111 222 333 7fe 7ff 0f 7ff
000 010 020 030 040 050 0c0 060 070 0c0 080 090 0a0 0b0 fff 800 09 0c0
000 100 200 2f0 2f0 1ff fff 800 2ef 000 001 002 c00 2e0 fff 003 04 2f0
// sign traps and ordered ramps
fff 800 801 fe0 100 fff 800 ffe 0ff 800 f00 801 fff fff 800 0fe 04 100
fff fff fff fff fff fff fff fff fff fff 000 fff fff fff fff fff 0a 000
1fe 1fd 1fc 1fb 1fa 1f9 1f8 1f7 1f6 1f5 1f4 1f3 1ff 1f2 1f1 1f0 0c 1ff
00f 00e 00d 00c 00b 00a 009 008 007 006 005 004 003 002 001 000 00 00f
001 fff 6b1 002 003 004 005 6b2 6b0 800 6ad fff 000 100 200 300 07 6b2
